//--- dc_alu.sv
//////////////////////////////////////////////////////////////////////
// alu with 4-bit lookahead carry groups, byte mode and
// n/z/v/c flag generation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module dc_alu
(
   input  dc_pkg::ctl_t           ctl,
   input  logic [`DC_WORD_W-1:0]  opa,
   input  logic [`DC_WORD_W-1:0]  opb,
   input  logic [`DC_WORD_W-1:0]  psw,
   output dc_pkg::alu_res_t       alu_out
);
   import dc_pkg::*;

   logic [`DC_WORD_W-1:0] b_in;        // b, inverted for subtract
   logic [`DC_WORD_W-1:0] g;           // generate
   logic [`DC_WORD_W-1:0] p;           // propagate
   logic [`DC_WORD_W:0]   cy;          // carry into each bit
   logic [`DC_WORD_W-1:0] sum;
   logic                  carry_out;
   logic                  ovf;

   assign b_in  = (ctl.fn == FN_SUB) ? ~opb : opb;
   assign cy[0] = (ctl.fn == FN_SUB);  // +1 completes two's complement
   assign g     = opa & b_in;
   assign p     = opa ^ b_in;

   for (genvar gi = 0; gi < `DC_WORD_W; gi = gi + 4)
   begin : gen_cla
      assign cy[gi+1] = g[gi]
                      | p[gi] & cy[gi];
      assign cy[gi+2] = g[gi+1]
                      | p[gi+1] & g[gi]
                      | p[gi+1] & p[gi] & cy[gi];
      assign cy[gi+3] = g[gi+2]
                      | p[gi+2] & g[gi+1]
                      | p[gi+2] & p[gi+1] & g[gi]
                      | p[gi+2] & p[gi+1] & p[gi] & cy[gi];
      assign cy[gi+4] = g[gi+3]
                      | p[gi+3] & g[gi+2]
                      | p[gi+3] & p[gi+2] & g[gi+1]
                      | p[gi+3] & p[gi+2] & p[gi+1] & g[gi]
                      | p[gi+3] & p[gi+2] & p[gi+1] & p[gi] & cy[gi];
   end

   assign sum       = p ^ cy[`DC_WORD_W-1:0];
   assign carry_out = ctl.byte_op ? cy[8] : cy[`DC_WORD_W];
   assign ovf       = ctl.byte_op ? (cy[7] ^ cy[8])
                                  : (cy[`DC_WORD_W-1] ^ cy[`DC_WORD_W]);

   always_comb
   begin
      case (ctl.fn)
         FN_ADD, FN_SUB: alu_out.res = sum;
         FN_AND:         alu_out.res = opa & opb;
         FN_BIC:         alu_out.res = opa & ~opb;
         FN_BIS:         alu_out.res = opa | opb;
         FN_XOR:         alu_out.res = opa ^ opb;
         FN_MOV:         alu_out.res = opb;
         default:        alu_out.res = {psw[0], opb[`DC_WORD_W-1:1]};
      endcase
      if (ctl.fn == FN_SHR && ctl.byte_op)
         alu_out.res[7] = psw[0];       // c enters the byte's top bit

      alu_out.flags.n = ctl.byte_op ? alu_out.res[7] : alu_out.res[`DC_WORD_W-1];
      alu_out.flags.z = ctl.byte_op ? (alu_out.res[7:0] == 8'h00)
                                    : (alu_out.res == '0);
      case (ctl.fn)
         FN_ADD:
         begin
            alu_out.flags.v = ovf;
            alu_out.flags.c = carry_out;
         end
         FN_SUB:
         begin
            alu_out.flags.v = ovf;
            alu_out.flags.c = ~carry_out;  // borrow
         end
         FN_SHR:
         begin
            alu_out.flags.c = opb[0];
            alu_out.flags.v = alu_out.flags.n ^ opb[0];
         end
         default:
         begin
            alu_out.flags.v = 1'b0;        // logic ops keep c
            alu_out.flags.c = psw[0];
         end
      endcase
   end

endmodule

//--- dc_branch.sv
//////////////////////////////////////////////////////////////////////
// microbranch test on psw and pdp-11 branch condition
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module dc_branch
(
   input  dc_pkg::ctl_t           ctl,
   input  logic [`DC_WORD_W-1:0]  psw,
   input  logic [`DC_WORD_W-1:0]  ir,
   output logic                   mbra,
   output logic                   bra
);
   import dc_pkg::*;

   flags_t f;

   assign f = psw[3:0];

   always_comb
   begin
      case (ctl.cond)
         3'd0:    mbra = f.n;
         3'd1:    mbra = f.z;
         3'd2:    mbra = f.c;
         3'd3:    mbra = f.v;
         3'd4:    mbra = f.n ^ f.v;               // less than
         3'd5:    mbra = f.z | (f.n ^ f.v);       // less or equal
         3'd6:    mbra = f.c | f.z;               // lower or same
         default: mbra = (psw[15:14] != 2'b00);   // not kernel
      endcase
      if (!ctl.test)
         mbra = 1'b0;
   end

   // ir bit 8 inverts the sense of each branch pair
   assign bra = ~ir[8] ^ ( ~ir[15] &  ir[10] & (f.n ^ f.v)
                         |  ir[15] & ~ir[10] & ~ir[9] & f.n
                         |  ir[15] &  ir[10] & ~ir[9] & f.v
                         |  ir[15] & ~ir[10] &  ir[9] & f.z
                         | ~ir[15] &  ir[9]  & f.z
                         |  ir[15] &  ir[9]  & f.c);

endmodule

//--- dc_chk.sv
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the data chip outputs and psw,
// bound into the top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module dc_chk
(
   input logic                  clk,
   input logic                  rst_n,
   input dc_pkg::mi_u           mi,
   input dc_pkg::ctl_t          ctl,
   input logic [`DC_WORD_W-1:0] din,
   input logic [`DC_WORD_W-1:0] dout,
   input logic [`DC_WORD_W-1:0] psw,
   input logic                  mbra
);
   import dc_pkg::*;

   // reset leaves a no-op control word
   mbra_after_reset: assert property (@(posedge clk) !rst_n |=> !mbra)
      else $error("mbra set in the cycle after reset");

   mbra_needs_test: assert property (@(posedge clk) !ctl.test |-> !mbra)
      else $error("mbra set without a test microinstruction");

   psw_unused_zero: assert property (@(posedge clk) disable iff (!rst_n)
      psw[10:8] == 3'b000)
      else $error("psw bits 10:8 not zero");

   load_passes_din: assert property (@(posedge clk) disable iff (!rst_n)
      mi.r.cls == `DC_CLS_LOAD |=> dout == din)
      else $error("dout does not follow din for a load");

endmodule

bind dc_top dc_chk u_chk (.clk(clk), .rst_n(rst_n), .mi(mi), .ctl(ctl),
                          .din(din), .dout(dout), .psw(psw), .mbra(mbra));

//--- dc_decode.sv
//////////////////////////////////////////////////////////////////////
// decode stage: microinstruction to registered control word
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module dc_decode
(
   input  logic          clk,
   input  logic          rst_n,
   input  dc_pkg::mi_u   mi,
   output dc_pkg::ctl_t  ctl
);
   import dc_pkg::*;

   ctl_t ctl_d;

   always_comb
   begin
      ctl_d = '0;
      if (mi.r.cls[3])                          // register view
      begin
         ctl_d.sa   = mi.r.sa;
         ctl_d.sb   = mi.r.sb;
         ctl_d.fn   = alu_fn_e'(mi.r.fn[2:0]);
         ctl_d.cond = mi.r.fn[2:0];             // same bits, test class
         case (mi.r.cls)
            `DC_CLS_ALU:  ctl_d.alu_en = 1'b1;
            `DC_CLS_BYTE:
            begin
               ctl_d.alu_en  = 1'b1;
               ctl_d.byte_op = 1'b1;
            end
            `DC_CLS_TEST: ctl_d.test   = 1'b1;
            `DC_CLS_IR:   ctl_d.ld_ir  = 1'b1;
            `DC_CLS_LOAD: ctl_d.ld_din = 1'b1;
            default:      ctl_d.alu_en = 1'b0;  // no-op classes
         endcase
      end
      else
      begin
         ctl_d.alu_en  = 1'b1;                  // immediate word op
         ctl_d.use_imm = 1'b1;
         ctl_d.fn      = mi.i.fn;
         ctl_d.imm     = {mi.i.imm_hi, mi.i.imm_lo};
         ctl_d.sa      = mi.i.sa;
      end
      // direct psw write must not be overwritten by the flags
      ctl_d.flag_en = ctl_d.alu_en & (ctl_d.sa != 4'(`DC_PSW_IDX));
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ctl <= '0;                             // no-op after reset
      else
         ctl <= ctl_d;
   end

endmodule

//--- dc_defs.svh
//////////////////////////////////////////////////////////////////////
// data chip macros: word width, register slots, special register
// indices and microinstruction class codes
//////////////////////////////////////////////////////////////////////
`ifndef DC_DEFS_SVH
`define DC_DEFS_SVH

`define DC_WORD_W   16          // data path width
`define DC_REG_N    16          // register file slots

`define DC_SP_IDX   6           // banked stack pointer select
`define DC_PSW_IDX  8           // processor status word slot
`define DC_SUP_SP   12          // supervisor stack slot
`define DC_USR_SP   13          // user stack slot
`define DC_IR_SRC   12          // select from ir source field
`define DC_IR_DST   13          // select from ir destination field

`define DC_CLS_ALU  4'b1000     // word alu
`define DC_CLS_BYTE 4'b1001     // byte alu, sign-extended b
`define DC_CLS_TEST 4'b1100     // microbranch test on psw
`define DC_CLS_IR   4'b1101     // instruction register load
`define DC_CLS_LOAD 4'b1110     // external data load

`endif

//--- dc_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types: alu function, microinstruction union,
// psw flags, decoded control word and alu result
//////////////////////////////////////////////////////////////////////
`include "dc_defs.svh"

package dc_pkg;

   typedef enum logic [2:0] {
      FN_ADD = 3'd0,            // a + b
      FN_SUB = 3'd1,            // a - b
      FN_AND = 3'd2,
      FN_BIC = 3'd3,            // a and not b
      FN_BIS = 3'd4,            // or
      FN_XOR = 3'd5,
      FN_MOV = 3'd6,            // pass b
      FN_SHR = 3'd7             // b >> 1, c into top bit
   } alu_fn_e;

   // register view, bit 15 set
   typedef struct packed {
      logic [3:0] cls;
      logic [3:0] fn;           // low bits are alu_fn_e or branch cond
      logic [3:0] sb;
      logic [3:0] sa;
   } mi_reg_t;

   // immediate view, bit 15 clear
   typedef struct packed {
      logic       zero;
      alu_fn_e    fn;
      logic [3:0] imm_lo;
      logic [3:0] imm_hi;
      logic [3:0] sa;
   } mi_imm_t;

   typedef union packed {
      mi_reg_t r;
      mi_imm_t i;
   } mi_u;

   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } flags_t;

   typedef struct packed {
      logic       alu_en;       // write alu result to a
      logic       byte_op;
      logic       use_imm;      // b from immediate
      logic       ld_din;
      logic       ld_ir;
      logic       test;         // microbranch test
      logic       flag_en;      // psw flag update
      alu_fn_e    fn;
      logic [2:0] cond;
      logic [3:0] sa;
      logic [3:0] sb;
      logic [7:0] imm;
   } ctl_t;

   typedef struct packed {
      logic [`DC_WORD_W-1:0] res;
      flags_t                flags;
   } alu_res_t;

endpackage

//--- dc_regfile.sv
//////////////////////////////////////////////////////////////////////
// register file: mode-banked stack pointer, ir field selects,
// instruction register, psw and execute-stage write-back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module dc_regfile
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  dc_pkg::ctl_t           ctl,
   input  logic [`DC_WORD_W-1:0]  din,
   input  dc_pkg::alu_res_t       alu_out,
   output logic [`DC_WORD_W-1:0]  opa,
   output logic [`DC_WORD_W-1:0]  opb,
   output logic [`DC_WORD_W-1:0]  psw,
   output logic [`DC_WORD_W-1:0]  ir
);
   import dc_pkg::*;

   logic [`DC_WORD_W-1:0] regs [`DC_REG_N];
   logic [`DC_WORD_W-1:0] ir_q;
   logic [`DC_WORD_W-1:0] b_raw;
   logic [`DC_WORD_W-1:0] wr_data;
   logic [3:0]            a_slot;
   logic [3:0]            b_slot;
   logic                  wr_en;

   // select code to physical slot
   function automatic logic [3:0] slot_of(input logic [3:0] sel,
                                           input logic [`DC_WORD_W-1:0] ir_v,
                                           input logic [1:0] mode);
      logic [3:0] s;
      s = sel;
      if (sel == 4'(`DC_IR_SRC))
         s = {1'b0, ir_v[8:6]};
      else if (sel == 4'(`DC_IR_DST))
         s = {1'b0, ir_v[2:0]};
      if (s == 4'(`DC_SP_IDX))
      begin
         case (mode)
            2'b00:   s = 4'(`DC_SP_IDX);      // kernel
            2'b01:   s = 4'(`DC_SUP_SP);
            default: s = 4'(`DC_USR_SP);
         endcase
      end
      return s;
   endfunction

   assign psw    = regs[`DC_PSW_IDX];
   assign ir     = ir_q;
   assign a_slot = slot_of(ctl.sa, ir_q, psw[15:14]);
   assign b_slot = slot_of(ctl.sb, ir_q, psw[15:14]);

   assign opa   = regs[a_slot];
   assign b_raw = ctl.use_imm ? {8'h00, ctl.imm} : regs[b_slot];
   assign opb   = ctl.byte_op ? {{8{b_raw[7]}}, b_raw[7:0]} : b_raw;

   always_comb
   begin
      wr_en   = ctl.alu_en | ctl.ld_din;
      wr_data = ctl.ld_din ? din : alu_out.res;
      if (ctl.byte_op)
         wr_data[15:8] = opa[15:8];            // upper byte kept
      if (a_slot == 4'(`DC_PSW_IDX))
         wr_data[10:8] = 3'b000;               // unused psw bits
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `DC_REG_N; i++)
            regs[i] <= '0;
         ir_q <= '0;
      end
      else
      begin
         if (wr_en)
            regs[a_slot] <= wr_data;
         if (ctl.flag_en)                      // never together with psw write
            regs[`DC_PSW_IDX][3:0] <= alu_out.flags;
         if (ctl.ld_ir)
            ir_q <= opa;
      end
   end

endmodule

//--- dc_top.sv
//////////////////////////////////////////////////////////////////////
// data chip top: decode, register file, alu and branch logic
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module dc_top
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  dc_pkg::mi_u            mi,
   input  logic [`DC_WORD_W-1:0]  din,
   output logic [`DC_WORD_W-1:0]  dout,
   output logic [`DC_WORD_W-1:0]  psw,
   output logic                   mbra,
   output logic                   bra
);
   import dc_pkg::*;

   ctl_t                  ctl;         // execute-stage control
   alu_res_t              alu_out;
   logic [`DC_WORD_W-1:0] opa;
   logic [`DC_WORD_W-1:0] opb;
   logic [`DC_WORD_W-1:0] ir;

   dc_decode u_decode (.clk(clk), .rst_n(rst_n), .mi(mi), .ctl(ctl));

   dc_regfile u_regfile (.clk(clk), .rst_n(rst_n), .ctl(ctl), .din(din),
                         .alu_out(alu_out), .opa(opa), .opb(opb),
                         .psw(psw), .ir(ir));

   dc_alu u_alu (.ctl(ctl), .opa(opa), .opb(opb), .psw(psw), .alu_out(alu_out));

   dc_branch u_branch (.ctl(ctl), .psw(psw), .ir(ir), .mbra(mbra), .bra(bra));

   assign dout = ctl.ld_din ? din : alu_out.res;   // load passes din through

endmodule

//--- run.sh
#!/bin/sh
# build the data chip testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dc -f src.f -o sim_dc
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_dc
status=$?
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit 1
fi
exit 0

//--- src.f
+incdir+.
dc_pkg.sv
dc_decode.sv
dc_alu.sv
dc_regfile.sv
dc_branch.sv
dc_top.sv
dc_chk.sv
tb_dc.sv

//--- tb_dc.sv
//////////////////////////////////////////////////////////////////////
// testbench for the data chip: clock, reset, random and directed
// microinstructions, shadow model checked by immediate assertions
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "dc_defs.svh"

module tb_dc;
   import dc_pkg::*;

   logic        clk;
   logic        rst_n;
   mi_u         mi;
   logic [15:0] din;
   logic [15:0] dout;
   logic [15:0] psw;
   logic        mbra;
   logic        bra;

   logic [15:0] m_regs [16];                 // shadow register file
   logic [15:0] m_ir;
   logic [15:0] prev_mi;                     // word now in execute
   logic [15:0] next_din;                    // din for the next execute cycle

   dc_top DUT (.clk(clk), .rst_n(rst_n), .mi(mi), .din(din), .dout(dout),
               .psw(psw), .mbra(mbra), .bra(bra));

   always #50 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_out(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
      assert (got === exp)
      else
         abort_run($sformatf("FAILED at %0t ns: %s expected %h, got %h",
                             $time, name, exp, got));
   endtask

   task automatic next_rise();
      int steps;
      steps = 0;
      while (clk !== 1'b0)
      begin
         #1;
         steps++;
         if (steps > 200)
            abort_run("clock did not fall within 200 ns");
      end
      while (clk !== 1'b1)
      begin
         #1;
         steps++;
         if (steps > 200)
            abort_run("clock did not rise within 200 ns");
      end
   endtask

   // select code to slot, ir fields first, then the stack bank
   function automatic logic [3:0] slot_for(input logic [3:0] sel);
      logic [3:0] s;
      s = sel;
      if (sel == 4'(`DC_IR_SRC))
         s = {1'b0, m_ir[8:6]};
      if (sel == 4'(`DC_IR_DST))
         s = {1'b0, m_ir[2:0]};
      if (s == 4'(`DC_SP_IDX) && m_regs[`DC_PSW_IDX][15:14] == 2'b01)
         s = 4'(`DC_SUP_SP);
      else if (s == 4'(`DC_SP_IDX) && m_regs[`DC_PSW_IDX][15] == 1'b1)
         s = 4'(`DC_USR_SP);
      return s;
   endfunction

   task automatic model_step(input logic [15:0] m, input logic [15:0] d);
      logic [3:0]  cls;
      logic [2:0]  fn;
      logic [3:0]  a_at;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [15:0] p;
      logic [15:0] wd;
      logic [16:0] sum;
      logic [8:0]  sum8;
      logic        by;
      logic        n;
      logic        z;
      logic        v;
      logic        c;
      logic        e_mbra;
      logic        e_bra;
      int          t;
      p    = m_regs[`DC_PSW_IDX];
      cls  = m[15] ? m[15:12] : `DC_CLS_ALU;    // immediates are word alu ops
      fn   = m[15] ? m[10:8] : m[14:12];
      by   = (cls == `DC_CLS_BYTE);
      a_at = slot_for(m[3:0]);
      a    = m_regs[a_at];
      b    = m[15] ? m_regs[slot_for(m[7:4])] : {8'h00, m[7:4], m[11:8]};
      if (by)
         b = {{8{b[7]}}, b[7:0]};
      t = by ? 7 : 15;
      case (fn)
         3'd0:    r = a + b;
         3'd1:    r = a - b;
         3'd2:    r = a & b;
         3'd3:    r = a & ~b;
         3'd4:    r = a | b;
         3'd5:    r = a ^ b;
         3'd6:    r = b;
         default: r = {p[0], b[15:1]};
      endcase
      if (by && fn == 3'd7)
         r[7] = p[0];
      n = r[t];
      z = by ? (r[7:0] == 8'h00) : (r == 16'h0000);
      v = 1'b0;
      c = p[0];
      if (fn == 3'd0)
      begin
         sum  = {1'b0, a} + {1'b0, b};
         sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]};
         c    = by ? sum8[8] : sum[16];
         v    = (a[t] == b[t]) && (r[t] != a[t]);
      end
      else if (fn == 3'd1)
      begin
         c = by ? (a[7:0] < b[7:0]) : (a < b);  // borrow
         v = (a[t] != b[t]) && (r[t] != a[t]);
      end
      else if (fn == 3'd7)
      begin
         c = b[0];
         v = n ^ b[0];
      end
      e_mbra = 1'b0;
      if (cls == `DC_CLS_TEST)
         case (fn)
            3'd0:    e_mbra = p[3];
            3'd1:    e_mbra = p[2];
            3'd2:    e_mbra = p[0];
            3'd3:    e_mbra = p[1];
            3'd4:    e_mbra = p[3] ^ p[1];
            3'd5:    e_mbra = p[2] | (p[3] ^ p[1]);
            3'd6:    e_mbra = p[0] | p[2];
            default: e_mbra = (p[15:14] != 2'b00);
         endcase
      e_bra = ~m_ir[8] ^ ((!m_ir[15] && m_ir[10] && (p[3] ^ p[1]))
                         || (m_ir[15] && !m_ir[10] && !m_ir[9] && p[3])
                         || (m_ir[15] && m_ir[10] && !m_ir[9] && p[1])
                         || (m_ir[15] && !m_ir[10] && m_ir[9] && p[2])
                         || (!m_ir[15] && m_ir[9] && p[2])
                         || (m_ir[15] && m_ir[9] && p[0]));
      check_out("dout", dout, (cls == `DC_CLS_LOAD) ? d : r);
      check_out("psw", psw, p);
      check_out("mbra", 16'(mbra), 16'(e_mbra));
      check_out("bra", 16'(bra), 16'(e_bra));
      if (cls == `DC_CLS_ALU || by || cls == `DC_CLS_LOAD)
      begin
         wd = (cls == `DC_CLS_LOAD) ? d : r;
         if (by)
            wd[15:8] = a[15:8];
         if (a_at == 4'(`DC_PSW_IDX))
            wd[10:8] = 3'b000;
         m_regs[a_at] = wd;
      end
      if ((cls == `DC_CLS_ALU || by) && m[3:0] != 4'(`DC_PSW_IDX))
         m_regs[`DC_PSW_IDX][3:0] = {n, z, v, c};
      if (cls == `DC_CLS_IR)
         m_ir = a;
   endtask

   // drive one word, then check the word that is now in execute
   task automatic issue(input logic [15:0] m, input logic [15:0] d);
      next_rise();
      #10;
      mi       = m;
      din      = next_din;
      next_din = d;
      #30;
      model_step(prev_mi, din);
      prev_mi = m;
   endtask

   function automatic logic [15:0] rand_mi();
      logic [15:0] m;
      logic [3:0]  sa;
      int          k;
      k  = int'($urandom_range(0, 9));
      sa = 4'($urandom_range(0, 15));
      if (sa == 4'(`DC_PSW_IDX) && $urandom_range(0, 7) != 0)
         sa = 4'd9;                          // mode changes stay rare
      m = 16'($urandom);
      case (k)
         0, 1, 2: m[15]    = 1'b0;
         3, 4:    m[15:12] = `DC_CLS_ALU;
         5, 6:    m[15:12] = `DC_CLS_BYTE;
         7:       m[15:12] = `DC_CLS_TEST;
         8:       m[15:12] = `DC_CLS_IR;
         default: m[15:12] = ($urandom_range(0, 1) != 0) ? `DC_CLS_LOAD : 4'hF;
      endcase
      m[3:0] = sa;
      return m;
   endfunction

   initial
   begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      mi       = 16'hF000;
      din      = '0;
      prev_mi  = 16'hF000;                   // same control word as reset
      next_din = '0;
      m_ir     = '0;
      for (int i = 0; i < 16; i++)
         m_regs[i] = '0;
      void'($urandom(66576));
      repeat (5)
         next_rise();
      #10;
      rst_n = 1'b1;
      for (int i = 0; i < 16; i++)
         issue({4'hF, 4'h6, 4'(i), 4'h0}, 16'h0000);
      for (int i = 0; i < 12; i++)
         if (i != 6 && i != 8)
            issue({`DC_CLS_LOAD, 8'h00, 4'(i)}, 16'($urandom));
      // carries across group boundaries, signed overflow, borrow, byte op
      issue({`DC_CLS_LOAD, 8'h00, 4'd0}, 16'h0FFF);
      issue({`DC_CLS_LOAD, 8'h00, 4'd1}, 16'h0001);
      issue({`DC_CLS_ALU, 4'd0, 4'd1, 4'd0}, 16'h0000);
      issue({`DC_CLS_LOAD, 8'h00, 4'd0}, 16'h7FFF);
      issue({`DC_CLS_ALU, 4'd0, 4'd1, 4'd0}, 16'h0000);
      issue({`DC_CLS_ALU, 4'd1, 4'd0, 4'd1}, 16'h0000);
      issue({`DC_CLS_LOAD, 8'h00, 4'd2}, 16'h1280);
      issue({`DC_CLS_BYTE, 4'd0, 4'd2, 4'd3}, 16'h0000);
      for (int i = 0; i < 300; i++)
         issue(rand_mi(), 16'($urandom));
      // one stack value per mode, then read each back
      for (int md = 0; md < 4; md++)
      begin
         issue({`DC_CLS_LOAD, 8'h00, 4'd8}, {2'(md), 14'h0000});
         issue({`DC_CLS_LOAD, 8'h00, 4'd6}, 16'($urandom));
      end
      for (int md = 0; md < 4; md++)
      begin
         issue({`DC_CLS_LOAD, 8'h00, 4'd8}, {2'(md), 14'h0000});
         issue({4'hF, 4'h6, 4'd6, 4'h0}, 16'h0000);
      end
      issue({`DC_CLS_LOAD, 8'h00, 4'd8}, 16'h0000);
      issue({`DC_CLS_LOAD, 8'h00, 4'd4}, 16'h0143);   // src 5, dst 3
      issue({`DC_CLS_IR, 8'h00, 4'd4}, 16'h0000);
      issue({4'hF, 4'h6, 4'd12, 4'h0}, 16'h0000);
      issue({4'hF, 4'h6, 4'd13, 4'h0}, 16'h0000);
      for (int i = 0; i < 32; i++)
      begin
         issue({`DC_CLS_LOAD, 8'h00, 4'd8}, 16'($urandom) & 16'hC00F);
         issue({`DC_CLS_LOAD, 8'h00, 4'd5}, 16'($urandom));
         issue({`DC_CLS_IR, 8'h00, 4'd5}, 16'h0000);
         issue({`DC_CLS_TEST, 1'b0, 3'(i), 8'h00}, 16'h0000);
      end
      issue(16'hF000, 16'h0000);
      issue(16'hF000, 16'h0000);
      $display("TB PASSED");
      $finish;
   end

endmodule
